// File: design/crc_pkg.sv
package crc_pkg;

	localparam logic [31:0] CRC32_POLY = 32'hedb88320;    // 802.3 polynomial, reflected
	localparam logic [31:0] CRC32_INIT = 32'hffffffff;

	function automatic logic [7:0] byte_reverse(input logic [7:0] b);
		logic [7:0] r;
		for (int i = 0; i < 8; i++) begin
			r[i] = b[7 - i];
		end
		return r;
	endfunction

	// ------------------------------------------------------------
	// one byte of CRC-32, bits taken in wire order
	// ------------------------------------------------------------
	function automatic logic [31:0] crc32_next(
		input logic [31:0] crc,
		input logic [7:0]  data
	);
		logic [31:0] c;
		logic [7:0]  d;
		c = crc;
		d = byte_reverse(data);    // lsb of data goes first on the wire
		for (int i = 0; i < 8; i++) begin
			if (c[0] ^ d[7])
				c = (c >> 1) ^ CRC32_POLY;
			else
				c = c >> 1;
			d = d << 1;
		end
		return c;
	endfunction

	// FCS byte idx of the finished register, lowest byte first
	function automatic logic [7:0] fcs_byte(
		input logic [31:0] crc,
		input logic [1:0]  idx
	);
		logic [31:0] inv;
		inv = ~crc;
		return inv[8 * idx +: 8];
	endfunction

endpackage

// File: design/eth_mac_buffered.sv
`timescale 1ns/1ps
`include "mac_defs.svh"

module eth_mac_buffered import mac_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       start_i,
	input  host_req_t  req_i,
	output logic       done_o,
	output logic [8:0] result_o,
	output gmii_t      gmii_tx_o,
	input  gmii_t      gmii_rx_i
);

	buf_wr_t   tx_wr;
	buf_rd_t   tx_rd;
	buf_stat_t tx_stat;
	buf_wr_t   rx_wr;
	buf_rd_t   rx_rd;
	buf_stat_t rx_stat;

	host_port u_host_port (
		.clock     (clock),
		.reset     (reset),
		.start_i   (start_i),
		.req_i     (req_i),
		.done_o    (done_o),
		.result_o  (result_o),
		.tx_wr_o   (tx_wr),
		.tx_stat_i (tx_stat),
		.rx_rd_o   (rx_rd),
		.rx_stat_i (rx_stat)
	);

	// ------------------------------------------------------------
	// transmit path
	// ------------------------------------------------------------
	packet_buffer #(.SLOTS(`MAC_TX_SLOTS)) u_tx_buf (
		.clock  (clock),
		.reset  (reset),
		.wr_i   (tx_wr),
		.rd_i   (tx_rd),
		.stat_o (tx_stat)
	);

	tx_framer u_tx_framer (
		.clock     (clock),
		.reset     (reset),
		.rd_o      (tx_rd),
		.stat_i    (tx_stat),
		.gmii_tx_o (gmii_tx_o)
	);

	// ------------------------------------------------------------
	// receive path
	// ------------------------------------------------------------
	packet_buffer #(.SLOTS(`MAC_RX_SLOTS)) u_rx_buf (
		.clock  (clock),
		.reset  (reset),
		.wr_i   (rx_wr),
		.rd_i   (rx_rd),
		.stat_o (rx_stat)
	);

	rx_deframer u_rx_deframer (
		.clock     (clock),
		.reset     (reset),
		.gmii_rx_i (gmii_rx_i),
		.wr_o      (rx_wr),
		.stat_i    (rx_stat)
	);

endmodule

// File: design/host_port.sv
`timescale 1ns/1ps
`include "mac_defs.svh"

module host_port import mac_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       start_i,
	input  host_req_t  req_i,
	output logic       done_o,
	output logic [8:0] result_o,
	output buf_wr_t    tx_wr_o,
	input  buf_stat_t  tx_stat_i,
	output buf_rd_t    rx_rd_o,
	input  buf_stat_t  rx_stat_i
);

	localparam logic [`MAC_ADDR_W-1:0] PKT_SIZE = `MAC_PACKET_SIZE;

	logic       in_range;
	logic       read_q;      // READ result arrives from the ring
	logic [8:0] result_d;
	logic [8:0] result_q;

	assign in_range = req_i.addr < PKT_SIZE;

	assign tx_wr_o.en      = start_i && req_i.op == OP_WRITE && in_range;
	assign tx_wr_o.addr    = req_i.addr;
	assign tx_wr_o.data    = req_i.value;
	assign tx_wr_o.commit  = start_i && req_i.op == OP_WRITE_NEXT && !tx_stat_i.full;
	assign tx_wr_o.discard = 1'b0;

	assign rx_rd_o.addr         = req_i.addr;
	assign rx_rd_o.release_slot = start_i && req_i.op == OP_READ_NEXT && rx_stat_i.avail;

	always_comb begin
		case (req_i.op)
			OP_READ_LEN:   result_d = 9'(rx_stat_i.rd_len);
			OP_READ_NEXT:  result_d = {8'h00, !rx_stat_i.avail};
			OP_WRITE:      result_d = {8'h00, !in_range};
			OP_WRITE_LEN:  result_d = 9'(tx_stat_i.wr_len);
			OP_WRITE_NEXT: result_d = {8'h00, tx_stat_i.full};
			default:       result_d = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			done_o   <= 1'b0;
			read_q   <= 1'b0;
			result_q <= '0;
		end else begin
			done_o <= start_i;
			read_q <= start_i && req_i.op == OP_READ;
			if (start_i && req_i.op != OP_READ)
				result_q <= result_d;
			if (read_q)
				result_q <= {1'b0, rx_stat_i.rd_data};    // hold until next done
		end
	end

	assign result_o = read_q ? {1'b0, rx_stat_i.rd_data} : result_q;

endmodule

// File: design/mac_defs.svh
`ifndef MAC_DEFS_SVH
`define MAC_DEFS_SVH

// ------------------------------------------------------------
// buffer geometry
// ------------------------------------------------------------
`define MAC_PACKET_SIZE     64
`define MAC_TX_SLOTS        4
`define MAC_RX_SLOTS        4
`define MAC_ADDR_W          ($clog2(`MAC_PACKET_SIZE) + 1)    // full length must fit

// ------------------------------------------------------------
// framing
// ------------------------------------------------------------
`define MAC_PREAMBLE_BYTE   8'h55
`define MAC_SFD_BYTE        8'hd5
`define MAC_PREAMBLE_LEN    7
`define MAC_IFG_LEN         12                                // idle cycles between frames

// reflected register, no final inversion
`define MAC_CRC_RESIDUE     32'hdebb20e3

`endif

// File: design/mac_pkg.sv
`include "mac_defs.svh"

package mac_pkg;

	typedef enum logic [2:0] {
		OP_READ,
		OP_READ_LEN,
		OP_READ_NEXT,
		OP_WRITE,
		OP_WRITE_LEN,
		OP_WRITE_NEXT
	} host_op_t;

	typedef struct packed {
		host_op_t               op;
		logic [`MAC_ADDR_W-1:0] addr;
		logic [7:0]             value;
	} host_req_t;

	// write side of a ring
	typedef struct packed {
		logic                   en;
		logic [`MAC_ADDR_W-1:0] addr;
		logic [7:0]             data;
		logic                   commit;
		logic                   discard;
	} buf_wr_t;

	// read side of a ring
	typedef struct packed {
		logic [`MAC_ADDR_W-1:0] addr;
		logic                   release_slot;
	} buf_rd_t;

	typedef struct packed {
		logic                   avail;
		logic                   full;
		logic [`MAC_ADDR_W-1:0] rd_len;
		logic [`MAC_ADDR_W-1:0] wr_len;
		logic [7:0]             rd_data;    // one cycle after rd addr
	} buf_stat_t;

	typedef struct packed {
		logic [7:0] data;
		logic       en;
		logic       er;
	} gmii_t;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_PREAMBLE,
		TX_SFD,
		TX_DATA,
		TX_FCS,
		TX_GAP
	} tx_state_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_PREAMBLE,
		RX_DATA,
		RX_DROP
	} rx_state_t;

endpackage

// File: design/packet_buffer.sv
`timescale 1ns/1ps
`include "mac_defs.svh"

module packet_buffer import mac_pkg::*; #(
	parameter int SLOTS = 4
) (
	input  logic      clock,
	input  logic      reset,
	input  buf_wr_t   wr_i,
	input  buf_rd_t   rd_i,
	output buf_stat_t stat_o
);

	localparam int PTR_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;
	localparam int CNT_W = $clog2(SLOTS + 1);
	localparam logic [`MAC_ADDR_W-1:0] PKT_SIZE = `MAC_PACKET_SIZE;

	logic [7:0]             mem [SLOTS][`MAC_PACKET_SIZE];
	logic [`MAC_ADDR_W-1:0] len_q [SLOTS];
	logic [PTR_W-1:0]       wr_ptr_q;
	logic [PTR_W-1:0]       rd_ptr_q;
	logic [PTR_W-1:0]       wr_ptr_inc;
	logic [PTR_W-1:0]       rd_ptr_inc;
	logic [CNT_W-1:0]       count_q;
	logic [CNT_W-1:0]       count_next;
	logic [7:0]             rd_data_q;
	logic                   avail;
	logic                   full;
	logic                   wr_ok;
	logic                   commit_ok;
	logic                   release_ok;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(SLOTS - 1)) ? '0 : p + 1'b1;
	endfunction

	assign wr_ptr_inc = ptr_inc(wr_ptr_q);
	assign rd_ptr_inc = ptr_inc(rd_ptr_q);

	assign avail      = count_q != '0;
	assign full       = count_q == CNT_W'(SLOTS);    // write slot overlaps the head
	assign wr_ok      = wr_i.en && !full && wr_i.addr < PKT_SIZE;
	assign commit_ok  = wr_i.commit && !full && len_q[wr_ptr_q] != '0;
	assign release_ok = rd_i.release_slot && avail;
	assign count_next = count_q + CNT_W'(commit_ok) - CNT_W'(release_ok);

	// ------------------------------------------------------------
	// pointers, count and slot lengths
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			for (int i = 0; i < SLOTS; i++) begin
				len_q[i] <= '0;
			end
		end else begin
			count_q <= count_next;
			if (wr_ok && wr_i.addr >= len_q[wr_ptr_q])
				len_q[wr_ptr_q] <= wr_i.addr + 1'b1;
			if (wr_i.discard && !full)
				len_q[wr_ptr_q] <= '0;
			if (commit_ok) begin
				wr_ptr_q <= wr_ptr_inc;
				if (count_next != CNT_W'(SLOTS))
					len_q[wr_ptr_inc] <= '0;    // open the next slot empty
			end
			if (release_ok) begin
				rd_ptr_q <= rd_ptr_inc;
				if (full)
					len_q[rd_ptr_q] <= '0;    // freed slot becomes the write slot
			end
		end
	end

	// ------------------------------------------------------------
	// byte storage
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (wr_ok)
			mem[wr_ptr_q][wr_i.addr[`MAC_ADDR_W-2:0]] <= wr_i.data;
		if (avail && rd_i.addr < len_q[rd_ptr_q])
			rd_data_q <= mem[rd_ptr_q][rd_i.addr[`MAC_ADDR_W-2:0]];
		else
			rd_data_q <= 8'h00;
	end

	assign stat_o.avail   = avail;
	assign stat_o.full    = full;
	assign stat_o.rd_len  = avail ? len_q[rd_ptr_q] : '0;
	assign stat_o.wr_len  = full ? '0 : len_q[wr_ptr_q];
	assign stat_o.rd_data = rd_data_q;

endmodule

// File: design/rx_deframer.sv
`timescale 1ns/1ps
`include "mac_defs.svh"

module rx_deframer import mac_pkg::*, crc_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  gmii_t     gmii_rx_i,
	output buf_wr_t   wr_o,
	input  buf_stat_t stat_i
);

	localparam int ADDR_W = `MAC_ADDR_W;
	localparam logic [ADDR_W-1:0] PKT_SIZE = `MAC_PACKET_SIZE;

	rx_state_t         state_q;
	logic [2:0]        pre_cnt_q;
	logic [ADDR_W-1:0] cnt_q;     // bytes after SFD
	logic [31:0]       crc_q;
	logic [31:0]       tail_q;    // newest four bytes, the FCS once the frame ends
	buf_wr_t           wr_q;
	logic              frame_ok;

	assign frame_ok = crc_q == `MAC_CRC_RESIDUE && cnt_q >= ADDR_W'(5);
	assign wr_o     = wr_q;

	// ------------------------------------------------------------
	// frame FSM, writes trail the wire by four bytes
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state_q   <= RX_IDLE;
			pre_cnt_q <= '0;
			cnt_q     <= '0;
			wr_q      <= '0;
		end else begin
			wr_q.en      <= 1'b0;
			wr_q.commit  <= 1'b0;
			wr_q.discard <= 1'b0;
			case (state_q)
				RX_IDLE: begin
					if (gmii_rx_i.en) begin
						if (stat_i.full || gmii_rx_i.er ||
						    gmii_rx_i.data != `MAC_PREAMBLE_BYTE) begin
							wr_q.discard <= 1'b1;
							state_q      <= RX_DROP;
						end else begin
							pre_cnt_q <= 3'd1;
							state_q   <= RX_PREAMBLE;
						end
					end
				end
				RX_PREAMBLE: begin
					if (!gmii_rx_i.en) begin
						state_q <= RX_IDLE;
					end else if (!gmii_rx_i.er && gmii_rx_i.data == `MAC_PREAMBLE_BYTE &&
					             pre_cnt_q != 3'(`MAC_PREAMBLE_LEN)) begin
						pre_cnt_q <= pre_cnt_q + 1'b1;
					end else if (!gmii_rx_i.er && gmii_rx_i.data == `MAC_SFD_BYTE &&
					             pre_cnt_q == 3'(`MAC_PREAMBLE_LEN)) begin
						cnt_q   <= '0;
						crc_q   <= CRC32_INIT;
						state_q <= RX_DATA;
					end else begin
						wr_q.discard <= 1'b1;
						state_q      <= RX_DROP;
					end
				end
				RX_DATA: begin
					if (!gmii_rx_i.en) begin
						// held-back FCS never reaches the ring
						wr_q.commit  <= frame_ok;
						wr_q.discard <= !frame_ok;
						state_q      <= RX_IDLE;
					end else if (gmii_rx_i.er || cnt_q == PKT_SIZE) begin
						wr_q.discard <= 1'b1;
						state_q      <= RX_DROP;
					end else begin
						crc_q  <= crc32_next(crc_q, gmii_rx_i.data);
						tail_q <= {tail_q[23:0], gmii_rx_i.data};
						cnt_q  <= cnt_q + 1'b1;
						if (cnt_q >= ADDR_W'(4)) begin
							wr_q.en   <= 1'b1;
							wr_q.addr <= cnt_q - ADDR_W'(4);
							wr_q.data <= tail_q[31:24];    // oldest held byte
						end
					end
				end
				RX_DROP: begin
					if (!gmii_rx_i.en)
						state_q <= RX_IDLE;
				end
				default: begin
					state_q <= RX_IDLE;
				end
			endcase
		end
	end

endmodule

// File: design/tx_framer.sv
`timescale 1ns/1ps
`include "mac_defs.svh"

module tx_framer import mac_pkg::*, crc_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	output buf_rd_t   rd_o,
	input  buf_stat_t stat_i,
	output gmii_t     gmii_tx_o
);

	tx_state_t              state_q;
	logic [3:0]             cnt_q;     // preamble, fcs and gap counter
	logic [`MAC_ADDR_W-1:0] addr_q;    // runs one byte ahead of the output
	logic [31:0]            crc_q;
	gmii_t                  tx_q;
	logic                   gap_done;

	assign gap_done = state_q == TX_GAP && cnt_q == 4'(`MAC_IFG_LEN - 1);

	assign rd_o.addr         = addr_q;
	assign rd_o.release_slot = gap_done;
	assign gmii_tx_o         = tx_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= TX_IDLE;
			cnt_q   <= '0;
			addr_q  <= '0;
			tx_q    <= '0;
		end else begin
			tx_q.er <= 1'b0;
			case (state_q)
				TX_IDLE: begin
					if (stat_i.avail) begin
						tx_q.en   <= 1'b1;
						tx_q.data <= `MAC_PREAMBLE_BYTE;
						cnt_q     <= 4'd1;
						state_q   <= TX_PREAMBLE;
					end
				end
				TX_PREAMBLE: begin
					cnt_q <= cnt_q + 1'b1;    // data holds 55
					if (cnt_q == 4'(`MAC_PREAMBLE_LEN - 1))
						state_q <= TX_SFD;
				end
				TX_SFD: begin
					tx_q.data <= `MAC_SFD_BYTE;
					crc_q     <= CRC32_INIT;
					addr_q    <= addr_q + 1'b1;    // byte 0 already fetched
					state_q   <= TX_DATA;
				end
				TX_DATA: begin
					tx_q.data <= stat_i.rd_data;
					crc_q     <= crc32_next(crc_q, stat_i.rd_data);
					if (addr_q == stat_i.rd_len) begin
						cnt_q   <= '0;
						state_q <= TX_FCS;
					end else begin
						addr_q <= addr_q + 1'b1;
					end
				end
				TX_FCS: begin
					tx_q.data <= fcs_byte(crc_q, cnt_q[1:0]);
					cnt_q     <= cnt_q + 1'b1;
					if (cnt_q == 4'd3) begin
						cnt_q   <= '0;
						state_q <= TX_GAP;
					end
				end
				TX_GAP: begin
					tx_q.en   <= 1'b0;
					tx_q.data <= 8'h00;
					cnt_q     <= cnt_q + 1'b1;
					if (gap_done) begin
						addr_q  <= '0;
						state_q <= TX_IDLE;
					end
				end
				default: begin
					state_q <= TX_IDLE;
				end
			endcase
		end
	end

endmodule

// File: files.f
+incdir+design
design/mac_pkg.sv
design/crc_pkg.sv
design/packet_buffer.sv
design/tx_framer.sv
design/rx_deframer.sv
design/host_port.sv
design/eth_mac_buffered.sv
sim/mac_checker.sv
sim/tb_eth_mac.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f files.f --top-module tb_eth_mac -o tb_eth_mac
./obj_dir/tb_eth_mac | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	echo "run failed, see sim.log"
	exit 1
fi
echo "run passed"

// File: sim/mac_checker.sv
`timescale 1ns/1ps
`include "mac_defs.svh"

module mac_checker import mac_pkg::*; (
	input  logic         clock,
	input  logic         reset,
	input  logic         start_i,
	input  logic         done_i,
	input  logic [8:0]   result_i,
	input  gmii_t        gmii_tx_i,
	input  logic [8:0]   exp_result_i,
	input  logic [127:0] exp_name_i,
	output int           mismatch_count_o,
	output int           fault_count_o,
	output int           tx_frames_o
);

	localparam int PAT_DEPTH = 256;

	logic [7:0]   pat [PAT_DEPTH];
	int           tx_off [$];    // first payload byte of each tx record
	int           tx_len [$];
	logic         armed = 1'b0;
	logic         reset_q;
	logic         start_q;
	logic [8:0]   exp_q;
	logic [127:0] name_q;
	logic         en_q = 1'b0;
	int           byte_idx = 0;
	int           gap = 0;
	int           frames = 0;
	int           mismatches = 0;
	int           faults = 0;

	assign mismatch_count_o = mismatches;
	assign fault_count_o    = faults;
	assign tx_frames_o      = frames;

	initial begin
		int p;
		int len;
		$readmemh("sim/mac_patterns.hex", pat);
		p = 0;
		while (p < PAT_DEPTH - 1 && pat[p] != 8'h00 && !$isunknown(pat[p])) begin
			len = int'(pat[p + 1]);
			if (pat[p] == 8'h01) begin
				tx_off.push_back(p + 2);
				tx_len.push_back(len);
			end
			p += 2 + len + ((pat[p] == 8'h01) ? 4 : 0);
		end
	end

	// preamble, SFD, then payload and file FCS back to back
	function automatic logic [7:0] tx_expected(input int f, input int j);
		if (j < `MAC_PREAMBLE_LEN)
			return `MAC_PREAMBLE_BYTE;
		if (j == `MAC_PREAMBLE_LEN)
			return `MAC_SFD_BYTE;
		return pat[tx_off[f] + j - `MAC_PREAMBLE_LEN - 1];
	endfunction

	always @(posedge clock) begin
		if (reset)
			armed <= 1'b1;
		reset_q <= reset;
		start_q <= start_i;
		if (start_i) begin
			exp_q  <= exp_result_i;
			name_q <= exp_name_i;
		end
	end

	// ------------------------------------------------------------
	// outputs are stable on the falling edge
	// ------------------------------------------------------------
	always @(negedge clock) begin
		if (armed) begin
			if (reset_q && (done_i || gmii_tx_i.en)) begin
				$display("DUT output active while reset is held");
				faults++;
			end
			if (done_i !== start_q) begin
				$display("Mismatch done_timing expected %0b actual %0b", start_q, done_i);
				mismatches++;
			end
			if (done_i && start_q && result_i !== exp_q) begin
				$display("Mismatch %s expected %h actual %h", name_q, exp_q, result_i);
				mismatches++;
			end
			if (gmii_tx_i.er !== 1'b0) begin
				$display("Mismatch tx_er expected 0 actual %b", gmii_tx_i.er);
				mismatches++;
			end
			if (gmii_tx_i.en) begin
				if (!en_q) begin
					byte_idx = 0;
					if (frames > 0 && gap < `MAC_IFG_LEN) begin
						$display("Mismatch tx_gap expected %0d actual %0d", `MAC_IFG_LEN, gap);
						mismatches++;
					end
					if (frames >= tx_len.size()) begin
						$display("frame sent on GMII with no packet committed");
						faults++;
					end
				end
				if (frames < tx_len.size() && byte_idx < tx_len[frames] + 12 &&
				    gmii_tx_i.data !== tx_expected(frames, byte_idx)) begin
					$display("Mismatch tx_frame%0d_byte%0d expected %h actual %h",
						frames, byte_idx, tx_expected(frames, byte_idx), gmii_tx_i.data);
					mismatches++;
				end
				byte_idx++;
				gap = 0;
			end else begin
				if (en_q) begin    // frame just ended
					if (frames < tx_len.size() && byte_idx != tx_len[frames] + 12) begin
						$display("Mismatch tx_frame%0d_len expected %0d actual %0d",
							frames, tx_len[frames] + 12, byte_idx);
						mismatches++;
					end
					frames++;
				end
				gap++;
			end
			en_q = gmii_tx_i.en;
		end
	end

endmodule

// File: sim/mac_patterns.hex
// record: kind, len, then len bytes; kind 01 adds its 4 expected FCS bytes after the payload
// kind 01 tx payload, 02 good rx frame, 03 rx frame with bad FCS, 04 rx frame with er on byte 2
01 2b
54 68 65 20 71 75 69 63 6b 20 62 72 6f 77 6e 20
66 6f 78 20 6a 75 6d 70 73 20 6f 76 65 72 20 74
68 65 20 6c 61 7a 79 20 64 6f 67
39 a3 4f 41
01 01 61 43 be b7 e8
01 03 61 62 63 c2 41 24 35
01 09 31 32 33 34 35 36 37 38 39 26 39 f4 cb
02 0d 31 32 33 34 35 36 37 38 39 26 39 f4 cb
02 07 61 62 63 c2 41 24 35
03 07 61 62 63 c2 41 24 36
04 0d 31 32 33 34 35 36 37 38 39 26 39 f4 cb
00

// File: sim/tb_eth_mac.sv
`timescale 1ns/1ps
`include "mac_defs.svh"

module tb_eth_mac import mac_pkg::*; ();

	localparam int PAT_DEPTH = 256;
	localparam int HOST_WAIT = 4;

	logic         clock;
	logic         reset;
	logic         start;
	host_req_t    req;
	logic         done;
	logic [8:0]   result;
	gmii_t        gmii_tx;
	gmii_t        gmii_rx;
	logic [8:0]   exp_result;
	logic [127:0] exp_name;
	logic [7:0]   pat [PAT_DEPTH];
	logic         loaded;
	int           pat_bytes;
	int           tx_records;
	int           host_faults;
	int           mismatch_count;
	int           fault_count;
	int           tx_frames;

	eth_mac_buffered u_eth_mac_buffered (
		.clock     (clock),
		.reset     (reset),
		.start_i   (start),
		.req_i     (req),
		.done_o    (done),
		.result_o  (result),
		.gmii_tx_o (gmii_tx),
		.gmii_rx_i (gmii_rx)
	);

	mac_checker u_checker (
		.clock            (clock),
		.reset            (reset),
		.start_i          (start),
		.done_i           (done),
		.result_i         (result),
		.gmii_tx_i        (gmii_tx),
		.exp_result_i     (exp_result),
		.exp_name_i       (exp_name),
		.mismatch_count_o (mismatch_count),
		.fault_count_o    (fault_count),
		.tx_frames_o      (tx_frames)
	);

	initial begin
		clock = 1'b0;
	end

	always #50 clock = ~clock;

	// ------------------------------------------------------------
	// host side
	// ------------------------------------------------------------
	task automatic host_cmd(input host_op_t op, input int addr, input logic [7:0] value,
			input logic [8:0] expected, input logic [127:0] name);
		int waited;
		@(negedge clock);
		start      = 1'b1;
		req.op     = op;
		req.addr   = addr[`MAC_ADDR_W-1:0];
		req.value  = value;
		exp_result = expected;    // checker latches it with the start
		exp_name   = name;
		@(negedge clock);
		start  = 1'b0;
		waited = 0;
		while (!done && waited < HOST_WAIT) begin
			@(negedge clock);
			waited++;
		end
		if (!done) begin
			$display("host command %s got no done pulse", name);
			host_faults++;
		end
	endtask

	task automatic load_tx_packet(input int off, input int len);
		for (int i = 0; i < len; i++) begin
			host_cmd(OP_WRITE, i, pat[off + i], 9'd0, "tx_write");
		end
		host_cmd(OP_WRITE_LEN, 0, 8'h00, 9'(len), "tx_write_len");
		host_cmd(OP_WRITE_NEXT, 0, 8'h00, 9'd0, "tx_commit");
	endtask

	task automatic check_rx_good(input int off, input int len);
		host_cmd(OP_READ_LEN, 0, 8'h00, 9'(len - 4), "rx_len");
		for (int i = 0; i < len - 4; i++) begin
			host_cmd(OP_READ, i, 8'h00, {1'b0, pat[off + i]}, "rx_read");
		end
		host_cmd(OP_READ, len - 4, 8'h00, 9'd0, "rx_read_end");    // beyond the length
		host_cmd(OP_READ_NEXT, 0, 8'h00, 9'd0, "rx_next");
		host_cmd(OP_READ_NEXT, 0, 8'h00, 9'd1, "rx_next_none");
	endtask

	task automatic check_rx_empty(input logic [127:0] len_name, input logic [127:0] next_name);
		host_cmd(OP_READ_LEN, 0, 8'h00, 9'd0, len_name);
		host_cmd(OP_READ_NEXT, 0, 8'h00, 9'd1, next_name);
	endtask

	// ------------------------------------------------------------
	// GMII receive side
	// ------------------------------------------------------------
	task automatic send_rx_frame(input int off, input int len, input int err_at);
		for (int i = 0; i < `MAC_PREAMBLE_LEN + 1 + len; i++) begin
			@(negedge clock);
			gmii_rx.en = 1'b1;
			gmii_rx.er = err_at >= 0 && i == err_at + `MAC_PREAMBLE_LEN + 1;
			if (i < `MAC_PREAMBLE_LEN)
				gmii_rx.data = `MAC_PREAMBLE_BYTE;
			else if (i == `MAC_PREAMBLE_LEN)
				gmii_rx.data = `MAC_SFD_BYTE;
			else
				gmii_rx.data = pat[off + i - `MAC_PREAMBLE_LEN - 1];
		end
		@(negedge clock);
		gmii_rx = '0;
		repeat (4) @(negedge clock);    // commit lands after enable falls
	endtask

	initial begin
		int p;
		int kind;
		int len;
		int tx_done;
		reset       = 1'b1;
		start       = 1'b0;
		req         = '0;
		gmii_rx     = '0;
		exp_result  = '0;
		exp_name    = '0;
		loaded      = 1'b0;
		host_faults = 0;
		tx_records  = 0;
		$readmemh("sim/mac_patterns.hex", pat);
		p = 0;
		while (p < PAT_DEPTH - 1 && pat[p] != 8'h00 && !$isunknown(pat[p])) begin
			if (pat[p] == 8'h01)
				tx_records++;
			p += 2 + int'(pat[p + 1]) + ((pat[p] == 8'h01) ? 4 : 0);
		end
		pat_bytes = p;
		loaded    = 1'b1;
		repeat (8) @(negedge clock);
		reset = 1'b0;

		check_rx_empty("reset_len", "reset_next");
		host_cmd(OP_WRITE, `MAC_PACKET_SIZE, 8'ha5, 9'd1, "write_oor");

		p       = 0;
		tx_done = 0;
		while (p < pat_bytes) begin
			kind = int'(pat[p]);
			len  = int'(pat[p + 1]);
			case (kind)
				1: begin
					load_tx_packet(p + 2, len);
					tx_done++;
					// first payload is long, so the framer still holds slot 0
					if (tx_done == `MAC_TX_SLOTS)
						host_cmd(OP_WRITE_NEXT, 0, 8'h00, 9'd1, "tx_full");
				end
				2: begin
					send_rx_frame(p + 2, len, -1);
					check_rx_good(p + 2, len);
				end
				3: begin
					send_rx_frame(p + 2, len, -1);
					check_rx_empty("rx_badcrc_len", "rx_badcrc_next");
				end
				4: begin
					send_rx_frame(p + 2, len, 2);
					check_rx_empty("rx_er_len", "rx_er_next");
				end
				default: begin
					$display("pattern file has an unknown record kind %0d", kind);
					host_faults++;
				end
			endcase
			p += 2 + len + ((kind == 1) ? 4 : 0);
		end

		while (tx_frames < tx_records)
			@(negedge clock);
		repeat (`MAC_IFG_LEN + 4) @(negedge clock);
		$display("checks finished with %0d mismatches and %0d other errors",
			mismatch_count, fault_count + host_faults);
		if (mismatch_count == 0 && fault_count + host_faults == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		int limit;
		wait (loaded);
		limit = pat_bytes * 40 + 2000;
		repeat (limit) @(posedge clock);
		$display("watchdog expired after %0d cycles before the tests finished", limit);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule
